/* verilog/sv_sound_pkg.sv */
`default_nettype none

package sv_sound_pkg;

	// Two identical square-wave tone channels
	localparam int num_tone_ch = 2;

	////////////////////////////////////////////////////////////////////////////
	// Address map
	// Each region spans 8 byte registers, matched on address bits 15..3
	localparam logic [15:0] snd_base = 16'h2010;
	localparam logic [15:0] sys_base = 16'h2020;

	// System region offsets
	localparam logic [2:0] joy_off     = 3'd0;
	localparam logic [2:0] timer_off   = 3'd3;
	localparam logic [2:0] sys_ctl_off = 3'd6;
	localparam logic [2:0] irq_ack_off = 3'd7;

	// Tone region, one group of four per channel
	localparam int tone_regs_per_ch = 4;
	localparam int freq_lo_off      = 0;
	localparam int freq_hi_off      = 1;
	localparam int vduty_off        = 2;
	localparam int length_off       = 3;

	// System control bits
	localparam int sys_ctl_irq_en_bit = 1;
	localparam int sys_ctl_slow_bit   = 4;

	////////////////////////////////////////////////////////////////////////////
	// Dividers
	// Prescaler reload values, so one timer step every 256 or 16384 cycles
	localparam int prescale_fast = 255;
	localparam int prescale_slow = 16383;
	localparam int presc_w       = $clog2(prescale_slow + 1);

	// Tone tick and waveform shape
	localparam int tone_div   = 4;
	localparam int tone_div_w = $clog2(tone_div);
	localparam int duty_steps = 8;
	localparam int step_w     = $clog2(duty_steps);
	localparam int len_ticks  = 64;
	localparam int len_cnt_w  = 8 + $clog2(len_ticks);
	localparam int freq_w     = 11;

	// Output routing, channel 1 goes right and channel 2 left
	localparam int audio_w  = 16;
	localparam int ch_right = 0;
	localparam int ch_left  = 1;

	typedef logic [3:0] level_t;

	// One channel as seen from its four registers
	typedef struct packed {
		logic [freq_w-1:0] freq;
		level_t            volume;
		logic [1:0]        duty;
		logic [7:0]        length;
	} tone_cfg_t;

endpackage

`default_nettype wire

/* verilog/reg_bus_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface reg_bus_if;

	// Access strobes, one cycle each
	logic       wr;
	logic       rd;
	// Region hits, already decoded
	logic       sel_sys;
	logic       sel_snd;
	logic [2:0] off;
	logic [7:0] wdata;
	// Read data, registered in each block
	logic [7:0] rdata_sys;
	logic [7:0] rdata_snd;

	// Bus side
	modport port (
		output wr, rd, sel_sys, sel_snd, off, wdata,
		input  rdata_sys, rdata_snd
	);

	// System register block
	modport sys (
		input  wr, rd, sel_sys, off, wdata,
		output rdata_sys
	);

	// Tone register block
	modport snd (
		input  wr, rd, sel_snd, off, wdata,
		output rdata_snd
	);

endinterface

`default_nettype wire

/* verilog/host_bus_port.sv */
`timescale 1ns/1ps
`default_nettype none

module host_bus_port
	import sv_sound_pkg::*;
(
	input  wire        clk_sys,
	input  wire        arst_n,
	input  wire        bus_req,
	input  wire        bus_we,
	input  wire [15:0] bus_addr,
	input  wire [7:0]  bus_wdata,
	output logic       bus_ack,
	output logic [7:0] bus_rdata,
	reg_bus_if.port    rb
);

	typedef enum logic [1:0] {
		st_idle,
		st_access,
		st_ack
	} state_t;

	state_t state;
	logic   hit_sys;
	logic   hit_snd;

	////////////////////////////////////////////////////////////////////////////
	// Region decode
	// Host keeps address and data stable until ack, no need to latch them
	assign hit_sys = (bus_addr[15:3] == sys_base[15:3]);
	assign hit_snd = (bus_addr[15:3] == snd_base[15:3]);

	// Strobe lives for the single access cycle
	assign rb.wr      = (state == st_access) && bus_we;
	assign rb.rd      = (state == st_access) && !bus_we;
	assign rb.sel_sys = hit_sys;
	assign rb.sel_snd = hit_snd;
	assign rb.off     = bus_addr[2:0];
	assign rb.wdata   = bus_wdata;

	////////////////////////////////////////////////////////////////////////////
	// Four-phase handshake
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			state     <= st_idle;
			bus_ack   <= 1'b0;
			bus_rdata <= 8'h00;
		end else begin
			case (state)
				// Wait for a request, ack already low here
				st_idle: begin
					if (bus_req)
						state <= st_access;
				end
				// Strobe cycle, block answers on the next edge
				st_access: begin
					state <= st_ack;
				end
				st_ack: begin
					if (!bus_ack) begin
						// Block read data valid now
						bus_ack <= 1'b1;
						if (!bus_we) begin
							bus_rdata <= hit_sys ? rb.rdata_sys :
							             hit_snd ? rb.rdata_snd : 8'hFF;
						end
					end else if (!bus_req) begin
						// Host released, close the cycle
						bus_ack <= 1'b0;
						state   <= st_idle;
					end
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	// Request has to be held over the whole access before ack shows up
	a_ack_needs_req: assert property (@(posedge clk_sys) disable iff (!arst_n)
		$rose(bus_ack) |-> $past(bus_req, 1) && $past(bus_req, 3));

endmodule

`default_nettype wire

/* verilog/sys_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module sys_timer
	import sv_sound_pkg::*;
(
	input  wire       clk_sys,
	input  wire       arst_n,
	reg_bus_if.sys    rb,
	input  wire [7:0] joy,
	output logic      irq
);

	logic [7:0]         sys_ctl;
	logic [7:0]         timer;
	logic [presc_w-1:0] presc;
	logic               presc_done;
	logic               wr_sys;
	logic               rd_sys;
	logic               wr_timer;
	logic               timer_zeroed;
	logic               irq_set;

	assign wr_sys   = rb.wr && rb.sel_sys;
	assign rd_sys   = rb.rd && rb.sel_sys;
	assign wr_timer = wr_sys && (rb.off == timer_off);

	// Control byte
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n)
			sys_ctl <= 8'h00;
		else if (wr_sys && rb.off == sys_ctl_off)
			sys_ctl <= rb.wdata;
	end

	////////////////////////////////////////////////////////////////////////////
	// Prescaler
	// Free running, reload picks the period from the slow bit
	assign presc_done = (presc == '0);

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n)
			presc <= '0;
		else if (presc_done)
			presc <= sys_ctl[sys_ctl_slow_bit] ? presc_w'(prescale_slow) :
			                                     presc_w'(prescale_fast);
		else
			presc <= presc - 1'b1;
	end

	////////////////////////////////////////////////////////////////////////////
	// IRQ timer
	// Counts down on each expiry and parks at zero
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n)
			timer <= 8'h00;
		else if (wr_timer)
			timer <= rb.wdata;
		else if (presc_done && timer != 8'h00)
			timer <= timer - 8'd1;
	end

	// The step from 1 to 0, not the zero level itself
	assign timer_zeroed = presc_done && !wr_timer && (timer == 8'd1);

	// Writing 0 fires straight away
	assign irq_set = sys_ctl[sys_ctl_irq_en_bit] &&
	                 (timer_zeroed || (wr_timer && rb.wdata == 8'h00));

	// Status bit, cleared by reading offset 7
	// a new event in the same cycle wins over the clear
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n)
			irq <= 1'b0;
		else if (irq_set)
			irq <= 1'b1;
		else if (rd_sys && rb.off == irq_ack_off)
			irq <= 1'b0;
	end

	// Read mux, sampled before the clear takes effect
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			rb.rdata_sys <= 8'h00;
		end else if (rd_sys) begin
			case (rb.off)
				joy_off:     rb.rdata_sys <= ~joy;
				timer_off:   rb.rdata_sys <= timer;
				sys_ctl_off: rb.rdata_sys <= sys_ctl;
				irq_ack_off: rb.rdata_sys <= {7'd0, irq};
				default:     rb.rdata_sys <= 8'hFF;
			endcase
		end
	end

	// Only a host write may move the timer up
	a_timer_no_rise: assert property (@(posedge clk_sys) disable iff (!arst_n)
		(timer > $past(timer)) |-> $past(wr_timer));

endmodule

`default_nettype wire

/* verilog/tone_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module tone_regs
	import sv_sound_pkg::*;
(
	input  wire                    clk_sys,
	input  wire                    arst_n,
	reg_bus_if.snd                 rb,
	output tone_cfg_t              cfg [num_tone_ch],
	output logic [num_tone_ch-1:0] restart,
	output logic                   tick
);

	logic [7:0]            regs [tone_regs_per_ch * num_tone_ch];
	logic [tone_div_w-1:0] div_cnt;
	logic                  wr_snd;
	logic                  rd_snd;

	assign wr_snd = rb.wr && rb.sel_snd;
	assign rd_snd = rb.rd && rb.sel_snd;

	////////////////////////////////////////////////////////////////////////////
	// Register file
	// Flat 8 entry map, offset picks the entry
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < tone_regs_per_ch * num_tone_ch; i++)
				regs[i] <= 8'h00;
		end else if (wr_snd) begin
			regs[rb.off] <= rb.wdata;
		end
	end

	// Full bytes read back, unused bits included
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n)
			rb.rdata_snd <= 8'h00;
		else if (rd_snd)
			rb.rdata_snd <= regs[rb.off];
	end

	// Fields of each channel's group
	always_comb begin
		for (int c = 0; c < num_tone_ch; c++) begin
			cfg[c].freq   = {regs[c * tone_regs_per_ch + freq_hi_off][2:0],
			                 regs[c * tone_regs_per_ch + freq_lo_off]};
			cfg[c].volume = regs[c * tone_regs_per_ch + vduty_off][3:0];
			cfg[c].duty   = regs[c * tone_regs_per_ch + vduty_off][5:4];
			cfg[c].length = regs[c * tone_regs_per_ch + length_off];
		end
	end

	// Length write restarts the channel
	// strobe lines up with the new length value
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			restart <= '0;
		end else begin
			for (int c = 0; c < num_tone_ch; c++)
				restart[c] <= wr_snd && (rb.off == 3'(c * tone_regs_per_ch + length_off));
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Tone tick
	// Shared by both channels and the output stage
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			div_cnt <= '0;
			tick    <= 1'b0;
		end else begin
			tick <= (div_cnt == tone_div_w'(tone_div - 1));
			if (div_cnt == tone_div_w'(tone_div - 1))
				div_cnt <= '0;
			else
				div_cnt <= div_cnt + 1'b1;
		end
	end

endmodule

`default_nettype wire

/* verilog/tone_channel.sv */
`timescale 1ns/1ps
`default_nettype none

module tone_channel
	import sv_sound_pkg::*;
(
	input  wire            clk_sys,
	input  wire            arst_n,
	input  wire tone_cfg_t cfg,
	input  wire            restart,
	input  wire            tick,
	output level_t         level
);

	logic [freq_w-1:0]    div_cnt;
	logic [step_w-1:0]    step;
	logic [step_w:0]      high_steps;
	logic [len_cnt_w-1:0] len_left;
	logic                 len_en;
	logic                 silent;
	logic                 step_high;

	// High part of the period per duty code
	always_comb begin
		case (cfg.duty)
			2'd0:    high_steps = 4'd1;
			2'd1:    high_steps = 4'd2;
			2'd2:    high_steps = 4'd4;
			default: high_steps = 4'd6;
		endcase
	end

	assign step_high = ({1'b0, step} < high_steps);

	// Length 0 never runs out
	assign silent = len_en && (len_left == '0);

	////////////////////////////////////////////////////////////////////////////
	// Divider, sequencer and length counter
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			div_cnt  <= '0;
			step     <= '0;
			len_left <= '0;
			len_en   <= 1'b0;
			level    <= '0;
		end else if (restart) begin
			// Start a fresh period and reload the length
			div_cnt  <= '0;
			step     <= '0;
			len_left <= len_cnt_w'(cfg.length) * len_cnt_w'(len_ticks);
			len_en   <= (cfg.length != 8'd0);
		end else if (tick) begin
			// Output only moves on ticks
			level <= (step_high && !silent) ? cfg.volume : '0;

			// freq+1 ticks per step
			// compare with >= so a smaller freq written mid-step still wraps
			if (div_cnt >= cfg.freq) begin
				div_cnt <= '0;
				if (step == step_w'(duty_steps - 1))
					step <= '0;
				else
					step <= step + 1'b1;
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end

			if (len_left != '0)
				len_left <= len_left - 1'b1;
		end
	end

	// On every tick the level still holds 0 or the volume seen one tick earlier
	a_level_is_volume: assert property (@(posedge clk_sys) disable iff (!arst_n)
		tick |-> (level == '0) || (level == $past(cfg.volume, tone_div)));

endmodule

`default_nettype wire

/* verilog/audio_out.sv */
`timescale 1ns/1ps
`default_nettype none

module audio_out
	import sv_sound_pkg::*;
(
	input  wire               clk_sys,
	input  wire               arst_n,
	input  wire               tick,
	input  wire level_t       levels [num_tone_ch],
	output logic [audio_w-1:0] audio_l,
	output logic [audio_w-1:0] audio_r
);

	////////////////////////////////////////////////////////////////////////////
	// Sample register
	// 4-bit level sits in the top bits, rest stays zero
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			audio_l <= '0;
			audio_r <= '0;
		end else if (tick) begin
			// Channel 1 to the right
			audio_r <= {levels[ch_right], {(audio_w - $bits(level_t)){1'b0}}};
			// Channel 2 to the left
			audio_l <= {levels[ch_left], {(audio_w - $bits(level_t)){1'b0}}};
		end
	end

endmodule

`default_nettype wire

/* verilog/supervision_sound.sv */
`timescale 1ns/1ps
`default_nettype none

module supervision_sound
	import sv_sound_pkg::*;
(
	input  wire               clk_sys,
	input  wire               arst_n,
	input  wire               bus_req,
	input  wire               bus_we,
	input  wire [15:0]        bus_addr,
	input  wire [7:0]         bus_wdata,
	input  wire [7:0]         joy,
	output wire               bus_ack,
	output wire [7:0]         bus_rdata,
	output wire               irq,
	output wire [audio_w-1:0] audio_l,
	output wire [audio_w-1:0] audio_r
);

	// Decoded register accesses
	reg_bus_if rb ();

	tone_cfg_t              cfg [num_tone_ch];
	logic [num_tone_ch-1:0] restart;
	logic                   tick;
	level_t                 levels [num_tone_ch];

	////////////////////////////////////////////////////////////////////////////
	// Host side
	host_bus_port u_host_bus_port (
		.clk_sys   (clk_sys),
		.arst_n    (arst_n),
		.bus_req   (bus_req),
		.bus_we    (bus_we),
		.bus_addr  (bus_addr),
		.bus_wdata (bus_wdata),
		.bus_ack   (bus_ack),
		.bus_rdata (bus_rdata),
		.rb        (rb)
	);

	// Joystick, timer and IRQ
	sys_timer u_sys_timer (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.rb      (rb),
		.joy     (joy),
		.irq     (irq)
	);

	////////////////////////////////////////////////////////////////////////////
	// Sound path
	tone_regs u_tone_regs (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.rb      (rb),
		.cfg     (cfg),
		.restart (restart),
		.tick    (tick)
	);

	// One channel per register group
	for (genvar i = 0; i < num_tone_ch; i++) begin : g_ch
		tone_channel u_tone_channel (
			.clk_sys (clk_sys),
			.arst_n  (arst_n),
			.cfg     (cfg[i]),
			.restart (restart[i]),
			.tick    (tick),
			.level   (levels[i])
		);
	end

	audio_out u_audio_out (
		.clk_sys (clk_sys),
		.arst_n  (arst_n),
		.tick    (tick),
		.levels  (levels),
		.audio_l (audio_l),
		.audio_r (audio_r)
	);

endmodule

`default_nettype wire

/* bench/tb_supervision_sound.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_supervision_sound;

	// Host view of the register map
	localparam logic [15:0] snd_addr = 16'h2010;
	localparam logic [15:0] sys_addr = 16'h2020;
	localparam int tick_cycles = 4;
	localparam int steps       = 8;
	localparam int len_unit    = 64;

	// Worst case length of each test in clk_sys cycles
	localparam int tone_cycles     = 4 * 5 * steps * 256 * tick_cycles;
	localparam int length_cycles   = (4 * len_unit + 2) * tick_cycles +
	                                 2 * steps * 8 * tick_cycles + 400;
	localparam int timer_cycles    = 17 * 256 + 400;
	localparam int bus_cycles      = 2000;
	localparam int test_cycles     = tone_cycles + length_cycles + timer_cycles + bus_cycles;
	localparam int watchdog_cycles = test_cycles + test_cycles / 2;

	logic        clk_sys = 1'b0;
	logic        arst_n;
	logic        bus_req;
	logic        bus_we;
	logic [15:0] bus_addr;
	logic [7:0]  bus_wdata;
	logic [7:0]  joy;
	wire         bus_ack;
	wire  [7:0]  bus_rdata;
	wire         irq;
	wire  [15:0] audio_l;
	wire  [15:0] audio_r;

	int          errors    = 0;
	int          accesses  = 0;
	int          cycle     = 0;
	int          ack_cycle = 0;
	logic [15:0] lfsr      = 16'd90;
	logic [7:0]  tone_shadow [8];
	// Volumes the outputs may show besides silence
	logic [3:0]  vol_r     = 4'h0;
	logic [3:0]  vol_l     = 4'h0;
	logic        quiet_l   = 1'b0;
	// High steps out of eight for duty 0..3
	int          duty_high [4] = '{1, 2, 4, 6};

	supervision_sound u_supervision_sound (
		.clk_sys   (clk_sys),
		.arst_n    (arst_n),
		.bus_req   (bus_req),
		.bus_we    (bus_we),
		.bus_addr  (bus_addr),
		.bus_wdata (bus_wdata),
		.joy       (joy),
		.bus_ack   (bus_ack),
		.bus_rdata (bus_rdata),
		.irq       (irq),
		.audio_l   (audio_l),
		.audio_r   (audio_r)
	);

	always #4 clk_sys = ~clk_sys;

	always @(posedge clk_sys)
		cycle <= cycle + 1;

	////////////////////////////////////////////////////////////////////////////
	// Bus and output checkers
	// Ack shows on the second edge after req is first seen
	a_ack_rise: assert property (@(posedge clk_sys) disable iff (!arst_n)
		$rose(bus_req) |=> !bus_ack ##1 !bus_ack ##1 bus_ack)
		else begin
			errors++;
			$display("bus_ack did not rise two cycles after bus_req, cycle %0d", cycle);
		end

	// Released request closes the cycle on the next edge
	a_ack_fall: assert property (@(posedge clk_sys) disable iff (!arst_n)
		bus_ack && !bus_req |=> !bus_ack)
		else begin
			errors++;
			$display("FAILED bus_ack exp %h got %h", 1'b0, bus_ack);
		end

	// Channel 1 on the right with the level in the top nibble only
	a_route_r: assert property (@(posedge clk_sys) disable iff (!arst_n)
		audio_r[11:0] == 12'h000 && (audio_r[15:12] == 4'h0 || audio_r[15:12] == vol_r))
		else begin
			errors++;
			$display("FAILED audio_r exp %h or 0000 got %h", {vol_r, 12'h000}, audio_r);
		end

	// Channel 2 on the left
	a_route_l: assert property (@(posedge clk_sys) disable iff (!arst_n)
		audio_l[11:0] == 12'h000 && (audio_l[15:12] == 4'h0 || audio_l[15:12] == vol_l))
		else begin
			errors++;
			$display("FAILED audio_l exp %h or 0000 got %h", {vol_l, 12'h000}, audio_l);
		end

	a_quiet_l: assert property (@(posedge clk_sys) disable iff (!arst_n)
		quiet_l |-> audio_l == 16'h0000)
		else begin
			errors++;
			$display("FAILED audio_l exp %h got %h", 16'h0000, audio_l);
		end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus helpers
	// Fibonacci LFSR with taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// One step per bit taken
	task automatic rand_bits(input int n, output logic [15:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			v = {v[14:0], lfsr[0]};
		end
	endtask

	// Four-phase access with data taken while ack is high
	task automatic bus_access(input logic we, input logic [15:0] addr,
		input logic [7:0] wdata, output logic [7:0] rdata);
		int waited;
		waited = 0;
		@(negedge clk_sys);
		bus_we    = we;
		bus_addr  = addr;
		bus_wdata = wdata;
		bus_req   = 1'b1;
		do begin
			@(negedge clk_sys);
			waited++;
		end while (!bus_ack && waited < 8);
		assert (bus_ack) else begin
			errors++;
			$display("No bus_ack within 8 cycles for address %h", addr);
		end
		ack_cycle = cycle;
		rdata     = bus_rdata;
		bus_req   = 1'b0;
		accesses++;
		waited = 0;
		do begin
			@(negedge clk_sys);
			waited++;
		end while (bus_ack && waited < 8);
		assert (!bus_ack) else begin
			errors++;
			$display("bus_ack stayed high after bus_req dropped, address %h", addr);
		end
	endtask

	// Tone writes also go to the shadow copy
	task automatic write_reg(input logic [15:0] addr, input logic [7:0] data);
		logic [7:0] unused;
		if (addr[15:3] == snd_addr[15:3])
			tone_shadow[addr[2:0]] = data;
		bus_access(1'b1, addr, data, unused);
	endtask

	task automatic read_check(input logic [15:0] addr, input logic [7:0] exp, input string name);
		logic [7:0] got;
		bus_access(1'b0, addr, 8'h00, got);
		assert (got === exp) else begin
			errors++;
			$display("FAILED bus_rdata (%s) exp %h got %h", name, exp, got);
		end
	endtask

	// Waits at falling edges for audio_r to go high or low
	task automatic wait_right(input logic want_high, input int limit, output int at);
		int waited;
		waited = 0;
		while ((audio_r != 16'h0) != want_high && waited < limit) begin
			@(negedge clk_sys);
			waited++;
		end
		assert ((audio_r != 16'h0) == want_high) else begin
			errors++;
			$display("audio_r did not go %s within %0d cycles",
				want_high ? "high" : "low", limit);
		end
		at = cycle;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	initial begin
		logic [15:0] r;
		logic [7:0]  ctl;
		logic [7:0]  vol;
		logic [7:0]  len;
		logic [7:0]  n;
		logic [7:0]  rd;
		logic [7:0]  prev;
		logic        seen;
		int          freq;
		int          period;
		int          r0;
		int          r1;
		int          f1;
		int          r2;
		int          deadline;
		arst_n    = 1'b0;
		bus_req   = 1'b0;
		bus_we    = 1'b0;
		bus_addr  = 16'h0000;
		bus_wdata = 8'h00;
		for (int i = 0; i < 8; i++)
			tone_shadow[i] = 8'h00;
		rand_bits(8, r);
		joy = r[7:0];
		repeat (16) @(negedge clk_sys);
		arst_n = 1'b1;
		assert (bus_ack === 1'b0 && irq === 1'b0 && audio_l === 16'h0 && audio_r === 16'h0)
			else begin
				errors++;
				$display("Outputs not all zero after reset");
			end

		// Handshake, control readback, joystick, unmapped reads
		// slow prescale kept off so the timer bound holds later
		rand_bits(8, r);
		ctl = r[7:0] & 8'hEF;
		write_reg(sys_addr + 16'd6, ctl);
		read_check(sys_addr + 16'd6, ctl, "sys_ctl");
		read_check(sys_addr, ~joy, "joy");
		read_check(16'h3000, 8'hFF, "unmapped");
		read_check(sys_addr + 16'd1, 8'hFF, "unused sys offset");

		// Tone shape on channel 1 for every duty at length 0
		rand_bits(4, r);
		vol = (r[3:0] == 4'h0) ? 8'h01 : {4'h0, r[3:0]};
		vol_r = vol[3:0];
		rand_bits(8, r);
		freq = r[7:0];
		period = steps * (freq + 1) * tick_cycles;
		write_reg(snd_addr, freq[7:0]);
		write_reg(snd_addr + 16'd1, 8'h00);
		for (int d = 0; d < 4; d++) begin
			write_reg(snd_addr + 16'd2, {2'b00, d[1:0], vol[3:0]});
			write_reg(snd_addr + 16'd3, 8'h00);
			// First run after the restart may be stretched so later ones are measured
			wait_right(1'b0, period + 16, r0);
			wait_right(1'b1, period + 16, r0);
			wait_right(1'b0, period + 16, f1);
			wait_right(1'b1, period + 16, r1);
			wait_right(1'b0, period + 16, f1);
			wait_right(1'b1, period + 16, r2);
			assert (f1 - r1 == duty_high[d] * (freq + 1) * tick_cycles) else begin
				errors++;
				$display("FAILED audio_r high run exp %h got %h",
					duty_high[d] * (freq + 1) * tick_cycles, f1 - r1);
			end
			assert (r2 - r1 == period) else begin
				errors++;
				$display("FAILED audio_r period exp %h got %h", period, r2 - r1);
			end
		end

		// Length on channel 2 with a short freq and half duty
		rand_bits(4, r);
		vol = (r[3:0] == 4'h0) ? 8'h01 : {4'h0, r[3:0]};
		vol_l = vol[3:0];
		rand_bits(3, r);
		write_reg(snd_addr + 16'd4, {5'd0, r[2:0]});
		write_reg(snd_addr + 16'd5, 8'h00);
		write_reg(snd_addr + 16'd6, {4'h2, vol[3:0]});
		rand_bits(2, r);
		len = r[1:0] + 8'd1;
		write_reg(snd_addr + 16'd7, len);
		deadline = ack_cycle + (len * len_unit + 2) * tick_cycles;
		seen = 1'b0;
		while (cycle < deadline) begin
			if (audio_l != 16'h0)
				seen = 1'b1;
			@(negedge clk_sys);
		end
		assert (seen) else begin
			errors++;
			$display("audio_l never sounded before its length ran out");
		end
		quiet_l = 1'b1;
		repeat (100) @(negedge clk_sys);
		quiet_l = 1'b0;
		// Length 0 restarts it with no end
		write_reg(snd_addr + 16'd7, 8'h00);
		seen = 1'b0;
		repeat (2 * steps * 8 * tick_cycles) begin
			if (audio_l != 16'h0)
				seen = 1'b1;
			@(negedge clk_sys);
		end
		assert (seen) else begin
			errors++;
			$display("audio_l stayed silent after the length restart");
		end

		// Tone register readback
		for (int i = 0; i < 8; i++)
			read_check(snd_addr + 16'(i), tone_shadow[i], "tone register");

		// Timer IRQ on the fast prescale
		write_reg(sys_addr + 16'd6, 8'h02);
		rand_bits(4, r);
		n = r[3:0] + 8'd1;
		write_reg(sys_addr + 16'd3, n);
		deadline = ack_cycle + (n + 1) * 256;
		prev = n;
		while (!irq && cycle < deadline) begin
			bus_access(1'b0, sys_addr + 16'd3, 8'h00, rd);
			assert (rd <= prev) else begin
				errors++;
				$display("FAILED timer exp <= %h got %h", prev, rd);
			end
			prev = rd;
		end
		assert (irq) else begin
			errors++;
			$display("irq did not rise within %0d cycles of the timer write", (n + 1) * 256);
		end
		read_check(sys_addr + 16'd3, 8'h00, "timer");
		read_check(sys_addr + 16'd7, 8'h01, "irq status");
		assert (!irq) else begin
			errors++;
			$display("irq still high after the status read");
		end
		read_check(sys_addr + 16'd7, 8'h00, "irq status");
		write_reg(sys_addr + 16'd3, 8'h00);
		assert (irq) else begin
			errors++;
			$display("irq not raised by writing 0 to the timer");
		end

		$display("Run done: %0d errors, %0d bus accesses", errors, accesses);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

	// Watchdog
	initial begin
		repeat (watchdog_cycles) @(posedge clk_sys);
		$display("Watchdog expired after %0d cycles, %0d errors", watchdog_cycles, errors);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* flist.f */
verilog/sv_sound_pkg.sv
verilog/reg_bus_if.sv
verilog/host_bus_port.sv
verilog/sys_timer.sv
verilog/tone_regs.sv
verilog/tone_channel.sv
verilog/audio_out.sv
verilog/supervision_sound.sv
bench/tb_supervision_sound.sv
